// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP = ordered_alu_tb
FILELIST = tb.f
OBJ_DIR = obj_dir
LOG = sim.log
FAIL_MSG = FAIL: see errors above
PASS_MSG = PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== logic/core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// outstanding operations, power of two
`define ROB_DEPTH 8

// ring index width, tags carry one extra wrap bit
`define TAG_W ($clog2(`ROB_DEPTH))

// operand and result width
`define DATA_W 16

// multiplier pipeline stages
`define MUL_LAT 3

`endif

// ==== logic/core_pkg.sv ====
`default_nettype none

`include "core_macros.svh"

package core_pkg;

	typedef enum logic [2:0] {
		OP_ADD = 3'd0,
		OP_SUB = 3'd1,
		OP_AND = 3'd2,
		OP_OR  = 3'd3,
		OP_XOR = 3'd4,
		OP_SHL = 3'd5,
		OP_SHR = 3'd6,
		OP_MUL = 3'd7
	} opcode_e;

	typedef enum logic {
		UNIT_ALU = 1'b0,
		UNIT_MUL = 1'b1
	} unit_e;

	// tag layout follows the loop pointer: index in [TAG_W:1], wrap in [0]
	typedef struct packed {
		opcode_e op;
		unit_e unit;
		logic [`DATA_W-1:0] a;
		logic [`DATA_W-1:0] b;
		logic [`TAG_W:0] tag;
	} issue_t;

	function automatic logic [`TAG_W:0] ring_inc(input logic [`TAG_W:0] ptr);
		logic [`TAG_W:0] nxt;
		nxt[`TAG_W:1] = ptr[`TAG_W:1] + 1'b1;
		// wrap bit flips when the index rolls over
		nxt[0] = (&ptr[`TAG_W:1]) ? ~ptr[0] : ptr[0];
		return nxt;
	endfunction

endpackage

`default_nettype wire

// ==== logic/exec_units.sv ====
`default_nettype none

`include "core_macros.svh"

module exec_units (
	input logic clk,
	input logic rst_i,
	issue_if.exec_mp issue,
	wb_if.exec_mp wb
);
	import core_pkg::*;

	localparam int SH_W = $clog2(`DATA_W);
	localparam int HALF = `DATA_W / 2;
	localparam int LAST = `MUL_LAT - 1;

	logic alu_go;
	logic mul_go;
	logic [`DATA_W-1:0] op_a;
	logic [`DATA_W-1:0] op_b;
	logic [`DATA_W-1:0] alu_res;
	logic [`DATA_W-1:0] lo_pp;
	logic [`DATA_W-1:0] hi_pp;
	logic [`DATA_W-1:0] mul_a;
	logic [HALF-1:0] mul_bh;
	logic [`MUL_LAT-1:0] mul_v;
	logic [`MUL_LAT-1:0][`TAG_W:0] mul_tag;
	logic [`MUL_LAT-1:0][`DATA_W-1:0] mul_p;

	assign op_a = issue.issue.a;
	assign op_b = issue.issue.b;
	assign alu_go = issue.issue_valid & (issue.issue.unit == UNIT_ALU);
	assign mul_go = issue.issue_valid & (issue.issue.unit == UNIT_MUL);

	always_comb begin
		case (issue.issue.op)
			OP_ADD: alu_res = op_a + op_b;
			OP_SUB: alu_res = op_a - op_b;
			OP_AND: alu_res = op_a & op_b;
			OP_OR:  alu_res = op_a | op_b;
			OP_XOR: alu_res = op_a ^ op_b;
			OP_SHL: alu_res = op_a << op_b[SH_W-1:0];
			OP_SHR: alu_res = op_a >> op_b[SH_W-1:0];
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_i) begin
		if (~rst_i) begin
			wb.alu_valid <= 1'b0;
		end else begin
			wb.alu_valid <= alu_go;
		end
	end

	always_ff @(posedge clk) begin
		wb.alu_tag <= issue.issue.tag;
		wb.alu_data <= alu_res;
	end

	// low half of b in stage 0, high half added in stage 1
	assign lo_pp = op_a * {{HALF{1'b0}}, op_b[HALF-1:0]};
	assign hi_pp = (mul_a * {{HALF{1'b0}}, mul_bh}) << HALF;

	always_ff @(posedge clk or negedge rst_i) begin
		if (~rst_i) begin
			mul_v <= '0;
		end else begin
			mul_v <= {mul_v[`MUL_LAT-2:0], mul_go};
		end
	end

	always_ff @(posedge clk) begin
		mul_a <= op_a;
		mul_bh <= op_b[`DATA_W-1:HALF];
		mul_tag[0] <= issue.issue.tag;
		mul_p[0] <= lo_pp;
		mul_tag[1] <= mul_tag[0];
		mul_p[1] <= mul_p[0] + hi_pp;
		// remaining stages only delay
		for (int i = 2; i < `MUL_LAT; i++) begin
			mul_tag[i] <= mul_tag[i-1];
			mul_p[i] <= mul_p[i-1];
		end
	end

	assign wb.mul_valid = mul_v[LAST];
	assign wb.mul_tag = mul_tag[LAST];
	assign wb.mul_data = mul_p[LAST];

endmodule

`default_nettype wire

// ==== logic/issue_if.sv ====
`default_nettype none

`include "core_macros.svh"

interface issue_if;
	import core_pkg::*;

	logic issue_valid;
	issue_t issue;

	modport decode_mp (
		output issue_valid,
		output issue
	);

	modport exec_mp (
		input issue_valid,
		input issue
	);

endinterface

`default_nettype wire

// ==== logic/op_decode.sv ====
`default_nettype none

`include "core_macros.svh"

module op_decode (
	input logic clk,
	input logic rst_i,
	input logic in_valid_i,
	input logic [2:0] in_op_i,
	input logic [`DATA_W-1:0] in_a_i,
	input logic [`DATA_W-1:0] in_b_i,
	input logic [`TAG_W:0] head_ptr_i,
	output logic full_o,
	issue_if.decode_mp issue
);
	import core_pkg::*;

	logic [`TAG_W:0] tail;
	logic accept;
	logic same_idx;
	logic wrap_diff;
	opcode_e op;
	unit_e unit;
	issue_t issue_d;

	// full when indexes match but the wrap bits differ
	assign same_idx = (tail[`TAG_W:1] == head_ptr_i[`TAG_W:1]);
	assign wrap_diff = tail[0] ^ head_ptr_i[0];
	assign full_o = same_idx & wrap_diff;

	assign accept = in_valid_i & ~full_o;

	always_comb begin
		op = opcode_e'(in_op_i);
		case (op)
			OP_MUL: unit = UNIT_MUL;
			default: unit = UNIT_ALU;
		endcase
	end

	always_comb begin
		issue_d.op = op;
		issue_d.unit = unit;
		issue_d.a = in_a_i;
		issue_d.b = in_b_i;
		// tag is the slot this operation will retire from
		issue_d.tag = tail;
	end

	always_ff @(posedge clk or negedge rst_i) begin
		if (~rst_i) begin
			tail <= '0;
			issue.issue_valid <= 1'b0;
		end else begin
			issue.issue_valid <= accept;
			if (accept) begin
				tail <= ring_inc(tail);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			issue.issue <= issue_d;
		end
	end

endmodule

`default_nettype wire

// ==== logic/ordered_alu_top.sv ====
`default_nettype none

`include "core_macros.svh"

module ordered_alu_top (
	input logic clk,
	input logic rst_i,
	input logic in_valid_i,
	input logic [2:0] in_op_i,
	input logic [`DATA_W-1:0] in_a_i,
	input logic [`DATA_W-1:0] in_b_i,
	input logic out_stall_i,
	output logic full_o,
	output logic out_valid_o,
	output logic [`DATA_W-1:0] out_data_o
);

	logic [`TAG_W:0] head_ptr;

	issue_if issue_bus ();
	wb_if wb_bus ();

	// decode and tag allocation
	op_decode u_decode (
		.clk        (clk),
		.rst_i      (rst_i),
		.in_valid_i (in_valid_i),
		.in_op_i    (in_op_i),
		.in_a_i     (in_a_i),
		.in_b_i     (in_b_i),
		.head_ptr_i (head_ptr),
		.full_o     (full_o),
		.issue      (issue_bus.decode_mp)
	);

	// results finish out of order here
	exec_units u_exec (
		.clk   (clk),
		.rst_i (rst_i),
		.issue (issue_bus.exec_mp),
		.wb    (wb_bus.exec_mp)
	);

	retire_buffer u_retire (
		.clk         (clk),
		.rst_i       (rst_i),
		.wb          (wb_bus.result_mp),
		.out_stall_i (out_stall_i),
		.head_ptr_o  (head_ptr),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o)
	);

endmodule

`default_nettype wire

// ==== logic/retire_buffer.sv ====
`default_nettype none

`include "core_macros.svh"

module retire_buffer (
	input logic clk,
	input logic rst_i,
	wb_if.result_mp wb,
	input logic out_stall_i,
	output logic [`TAG_W:0] head_ptr_o,
	output logic out_valid_o,
	output logic [`DATA_W-1:0] out_data_o
);
	import core_pkg::*;

	logic [`DATA_W-1:0] data_mem [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] done;
	logic [`TAG_W:0] head;
	logic [`TAG_W-1:0] head_idx;
	logic [`TAG_W-1:0] alu_idx;
	logic [`TAG_W-1:0] mul_idx;
	logic retire;

	// entries are addressed without the wrap bit
	assign head_idx = head[`TAG_W:1];
	assign alu_idx = wb.alu_tag[`TAG_W:1];
	assign mul_idx = wb.mul_tag[`TAG_W:1];

	assign retire = ~out_stall_i & done[head_idx];
	assign head_ptr_o = head;

	always_ff @(posedge clk or negedge rst_i) begin
		if (~rst_i) begin
			done <= '0;
			head <= '0;
			out_valid_o <= 1'b0;
		end else begin
			out_valid_o <= retire;
			if (retire) begin
				done[head_idx] <= 1'b0;
				head <= ring_inc(head);
			end
			// new results never land on the retiring slot
			if (wb.alu_valid) begin
				done[alu_idx] <= 1'b1;
			end
			if (wb.mul_valid) begin
				done[mul_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wb.alu_valid) begin
			data_mem[alu_idx] <= wb.alu_data;
		end
		if (wb.mul_valid) begin
			data_mem[mul_idx] <= wb.mul_data;
		end
	end

	always_ff @(posedge clk) begin
		if (retire) begin
			out_data_o <= data_mem[head_idx];
		end
	end

endmodule

`default_nettype wire

// ==== logic/wb_if.sv ====
`default_nettype none

`include "core_macros.svh"

interface wb_if;
	logic alu_valid;
	logic [`TAG_W:0] alu_tag;
	logic [`DATA_W-1:0] alu_data;
	logic mul_valid;
	logic [`TAG_W:0] mul_tag;
	logic [`DATA_W-1:0] mul_data;

	modport exec_mp (
		output alu_valid, alu_tag, alu_data,
		output mul_valid, mul_tag, mul_data
	);

	// both ports may write in the same cycle
	modport result_mp (
		input alu_valid, alu_tag, alu_data,
		input mul_valid, mul_tag, mul_data
	);

endinterface

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/core_pkg.sv
logic/issue_if.sv
logic/wb_if.sv
logic/op_decode.sv
logic/exec_units.sv
logic/retire_buffer.sv
logic/ordered_alu_top.sv
tb/ordered_alu_assert.sv
tb/ordered_alu_tb.sv

// ==== tb/ordered_alu_assert.sv ====
`default_nettype none

`include "core_macros.svh"

module ordered_alu_assert (
	input logic clk,
	input logic rst_i,
	input logic [`TAG_W:0] tail_i,
	input logic [`TAG_W:0] head_i,
	input logic full_i,
	input logic issue_valid_i,
	input logic [`ROB_DEPTH-1:0] done_i,
	input logic alu_valid_i,
	input logic [`TAG_W:0] alu_tag_i,
	input logic mul_valid_i,
	input logic [`TAG_W:0] mul_tag_i,
	input logic out_stall_i,
	input logic out_valid_i
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [`TAG_W:0] occ;

	// wrap bit sits at [0], move it on top before subtracting
	assign occ = {tail_i[0], tail_i[`TAG_W:1]} - {head_i[0], head_i[`TAG_W:1]};

	a_occupancy: assert property (@(posedge clk) disable iff (!rst_i)
		occ <= `ROB_DEPTH)
		else $error("more operations in flight than buffer entries");

	a_no_issue_when_full: assert property (@(posedge clk) disable iff (!rst_i)
		full_i |=> !issue_valid_i)
		else $error("operation issued from an edge where the buffer was full");

	a_alu_slot_free: assert property (@(posedge clk) disable iff (!rst_i)
		alu_valid_i |-> !done_i[alu_tag_i[`TAG_W:1]])
		else $error("ALU write-back hit an entry still marked done");

	a_mul_slot_free: assert property (@(posedge clk) disable iff (!rst_i)
		mul_valid_i |-> !done_i[mul_tag_i[`TAG_W:1]])
		else $error("multiplier write-back hit an entry still marked done");

	a_no_out_when_stalled: assert property (@(posedge clk) disable iff (!rst_i)
		out_stall_i |=> !out_valid_i)
		else $error("result retired from a stalled edge");

endmodule

// decode side ties off the retire inputs, and the other way round
bind op_decode ordered_alu_assert u_decode_chk (
	.clk (clk), .rst_i (rst_i),
	.tail_i (tail), .head_i (head_ptr_i),
	.full_i (full_o), .issue_valid_i (issue.issue_valid),
	.done_i ('0), .alu_valid_i (1'b0), .alu_tag_i ('0),
	.mul_valid_i (1'b0), .mul_tag_i ('0),
	.out_stall_i (1'b0), .out_valid_i (1'b0)
);

bind retire_buffer ordered_alu_assert u_retire_chk (
	.clk (clk), .rst_i (rst_i),
	.tail_i (head), .head_i (head),
	.full_i (1'b0), .issue_valid_i (1'b0),
	.done_i (done), .alu_valid_i (wb.alu_valid), .alu_tag_i (wb.alu_tag),
	.mul_valid_i (wb.mul_valid), .mul_tag_i (wb.mul_tag),
	.out_stall_i (out_stall_i), .out_valid_i (out_valid_o)
);

`default_nettype wire

// ==== tb/ordered_alu_tb.sv ====
`default_nettype none

`include "core_macros.svh"

module ordered_alu_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import core_pkg::*;

	localparam int NUM_OPS = 400;
	localparam int TIMEOUT = NUM_OPS * 8 + 200;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic [2:0] in_op_i;
	logic [`DATA_W-1:0] in_a_i;
	logic [`DATA_W-1:0] in_b_i;
	logic out_stall_i;
	logic full_o;
	logic out_valid_o;
	logic [`DATA_W-1:0] out_data_o;

	logic [15:0] lfsr;
	logic stall_seen;
	int errors;
	int cyc;
	int accepted;
	int retired;
	int last_latency;
	logic [`DATA_W-1:0] exp_q[$];
	int acc_cyc_q[$];

	ordered_alu_top uut (
		.clk         (clk),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_op_i     (in_op_i),
		.in_a_i      (in_a_i),
		.in_b_i      (in_b_i),
		.out_stall_i (out_stall_i),
		.full_o      (full_o),
		.out_valid_o (out_valid_o),
		.out_data_o  (out_data_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic draw(input int nbits, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < nbits; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic logic [`DATA_W-1:0] model_result(input logic [2:0] op,
			input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
		logic [31:0] prod;
		prod = 32'(a) * 32'(b);
		case (op)
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR: return a | b;
			OP_XOR: return a ^ b;
			OP_SHL: return a << b[3:0];
			OP_SHR: return a >> b[3:0];
			default: return prod[15:0];
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s got %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic send(input logic valid, input logic [2:0] op, input logic [15:0] a,
			input logic [15:0] b, input logic stall);
		@(posedge clk);
		#1;
		in_valid_i = valid;
		in_op_i = op;
		in_a_i = a;
		in_b_i = b;
		out_stall_i = stall;
	endtask

	task automatic wait_retired(input int target);
		while (retired < target) @(posedge clk);
	endtask

	task automatic drain();
		while (exp_q.size() != 0) @(posedge clk);
	endtask

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// inputs and outputs are both settled at the falling edge
	always @(negedge clk) begin : monitor
		logic [`DATA_W-1:0] exp_val;
		if (rst_i) begin
			if (out_valid_o) begin
				if (stall_seen) begin
					$display("Error at time %0t: result left after a stalled edge", $time);
					errors++;
				end
				if (exp_q.size() == 0) begin
					$display("Error at time %0t: result with no operation pending", $time);
					errors++;
				end else begin
					exp_val = exp_q.pop_front();
					last_latency = cyc - acc_cyc_q.pop_front();
					check_value("out_data_o", out_data_o, exp_val);
				end
				retired++;
			end
			if (in_valid_i && !full_o) begin
				exp_q.push_back(model_result(in_op_i, in_a_i, in_b_i));
				acc_cyc_q.push_back(cyc + 1);
				accepted++;
			end
			stall_seen = out_stall_i;
		end
	end

	initial begin
		logic [31:0] r;
		logic valid;
		logic stall;
		logic [2:0] rnd_op;
		logic [15:0] rnd_a;
		logic [15:0] rnd_b;
		int base;
		int burst;
		int n;
		lfsr = 16'd56;
		errors = 0;
		cyc = 0;
		accepted = 0;
		retired = 0;
		stall_seen = 1'b0;
		rst_i = 1'b0;
		in_valid_i = 1'b0;
		in_op_i = '0;
		in_a_i = '0;
		in_b_i = '0;
		out_stall_i = 1'b0;
		repeat (2) @(posedge clk);
		#1 rst_i = 1'b1;
		check_value("full_o", full_o, 0);
		check_value("out_valid_o", out_valid_o, 0);

		// isolated latencies
		send(1'b1, OP_ADD, 16'h0102, 16'h0304, 1'b0);
		send(1'b0, OP_ADD, '0, '0, 1'b0);
		wait_retired(1);
		check_value("alu latency", last_latency, 3);
		send(1'b1, OP_MUL, 16'h0011, 16'h0022, 1'b0);
		send(1'b0, OP_ADD, '0, '0, 1'b0);
		wait_retired(2);
		check_value("mul latency", last_latency, 5);

		// slow multiply first, then edge cases
		send(1'b1, OP_MUL, 16'hffff, 16'hffff, 1'b0);
		send(1'b1, OP_ADD, 16'hfff0, 16'h0020, 1'b0);
		send(1'b1, OP_SUB, 16'h0000, 16'h0001, 1'b0);
		send(1'b1, OP_AND, 16'hf0f0, 16'h3c3c, 1'b0);
		send(1'b1, OP_OR, 16'hf000, 16'h000f, 1'b0);
		send(1'b1, OP_XOR, 16'haaaa, 16'hffff, 1'b0);
		send(1'b1, OP_SHL, 16'h8001, 16'h0000, 1'b0);
		send(1'b1, OP_SHL, 16'h0003, 16'h000f, 1'b0);
		send(1'b1, OP_SHR, 16'h8001, 16'h0010, 1'b0);
		send(1'b1, OP_SHR, 16'h8000, 16'hffff, 1'b0);
		send(1'b1, OP_MUL, 16'h1234, 16'h5678, 1'b0);
		send(1'b0, OP_ADD, '0, '0, 1'b0);
		drain();

		// fill against a stalled output
		base = accepted;
		for (int i = 0; i < `ROB_DEPTH + 4; i++) begin
			send(1'b1, OP_XOR, 16'(i), 16'h5a5a, 1'b1);
			check_value("full_o", full_o, (accepted - base) >= `ROB_DEPTH);
		end
		check_value("accepted while stalled", accepted - base, `ROB_DEPTH);
		send(1'b0, OP_ADD, '0, '0, 1'b0);
		drain();

		stall = 1'b0;
		burst = 0;
		n = 0;
		while (n < NUM_OPS) begin
			draw(2, r);
			valid = (r[1:0] != 2'b00);
			draw(3, r);
			rnd_op = r[2:0];
			draw(16, r);
			rnd_a = r[15:0];
			draw(16, r);
			rnd_b = r[15:0];
			if (n < 150) begin
				draw(4, r);
				stall = (r[3:0] == 4'd0);
			end else if (n < 300) begin
				if (burst == 0) begin
					stall = ~stall;
					draw(4, r);
					burst = stall ? 12 + int'(r[3:0]) : 1 + int'(r[1:0]);
				end
				burst--;
			end else begin
				stall = 1'b0;
			end
			send(valid, rnd_op, rnd_a, rnd_b, stall);
			if (valid) begin
				n++;
			end
		end
		send(1'b0, OP_ADD, '0, '0, 1'b0);
		drain();
		repeat (4) @(posedge clk);
		check_value("retired count", retired, accepted);
		if (exp_q.size() != 0) begin
			$display("Error: %0d accepted operations never reached the output", exp_q.size());
			errors++;
		end
		$display("errors: %0d, accepted: %0d, retired: %0d", errors, accepted, retired);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire
